//--- dmix_top.f
+incdir+.
dmix_pkg.sv
sample_pairer.sv
ringbuf.sv
dac_drv.sv
dmix_top.sv
dmix_assertions.sv
dmix_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module dmix_tb -f dmix_top.f &&
./obj_dir/Vdmix_tb | tee /dev/stderr | grep -qF '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- dmix_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmix_cfg.svh"

module dmix_tb import dmix_pkg::*; ();

    localparam int SW        = `DMIX_SAMPLE_W;
    localparam int FRAME_BCK = 2 * `DMIX_SLOT_BITS;
    localparam int FRAME_CYC = FRAME_BCK * `DMIX_BCK_DIV;

    logic       clk491520;
    logic       rst_ip;
    chan_word_t in_word_i;
    logic       in_valid_i;
    logic       in_ready_o;
    logic       dac_bck_o;
    logic       dac_lrck_o;
    logic       dac_data_o;

    logic [31:0] lfsr_q;
    chan_word_t  words_q[$];
    frame_t      exp_q[$];
    string       test_name;
    int          value_errs;
    int          other_errs;
    int          quiet_frames;
    logic        stalled;
    sample_t     slot_acc;
    sample_t     left_acc;
    int          slot_pos;
    int          bck_count;
    logic        prev_lrck;
    logic        synced;

    dmix_top dut (.*);

    always #5 clk491520 = ~clk491520;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic push_word(input logic is_right);
        chan_word_t w;
        w = '0;
        for (int i = 0; i < SW; i++) begin
            w.data = {w.data[SW-2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        // Zero stays reserved for silence
        if (w.data == '0) w.data = sample_t'(1);
        w.is_right = is_right;
        words_q.push_back(w);
    endtask

    task automatic push_pair();
        push_word(1'b0);
        push_word(1'b1);
    endtask

    // Reference model of the pairing rules
    function automatic void pair_words();
        sample_t held;
        logic    have;
        held = '0;
        have = 1'b0;
        foreach (words_q[i]) begin
            if (!words_q[i].is_right) begin
                held = words_q[i].data;
                have = 1'b1;
            end else if (have) begin
                exp_q.push_back({held, words_q[i].data});
                have = 1'b0;
            end
        end
    endfunction

    task automatic check_frame(input string name, input frame_t exp, input frame_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic idle(input int n);
        @(negedge clk491520);
        in_valid_i = 1'b0;
        repeat (n) @(negedge clk491520);
    endtask

    task automatic send_word(input chan_word_t w);
        int n;
        n = 0;
        @(negedge clk491520);
        in_word_i  = w;
        in_valid_i = 1'b1;
        while (!in_ready_o && n < 4 * FRAME_CYC) begin
            stalled = 1'b1;
            @(negedge clk491520);
            n++;
        end
        if (!in_ready_o) begin
            $display("%s: input word was never accepted", test_name);
            other_errs++;
        end
    endtask

    task automatic send_words(input int gap);
        chan_word_t w;
        pair_words();
        while (words_q.size() != 0) begin
            w = words_q.pop_front();
            send_word(w);
            if (w.is_right && gap > 0) idle(gap);
        end
        idle(1);
    endtask

    task automatic wait_drain();
        int n;
        int limit;
        n = 0;
        limit = (exp_q.size() + 4) * FRAME_CYC;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge clk491520);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d frames never reached the DAC pins", test_name, exp_q.size());
            other_errs++;
        end
    endtask

    task automatic wait_quiet(input int count);
        int n;
        int target;
        n = 0;
        target = quiet_frames + count;
        while (quiet_frames < target && n < (count + 2) * FRAME_CYC) begin
            @(negedge clk491520);
            n++;
        end
        if (quiet_frames < target) begin
            $display("%s: no silent frames were played after the stream stopped", test_name);
            other_errs++;
        end
    endtask

    task automatic take_frame(input frame_t f);
        if (exp_q.size() == 0) begin
            check_sample({test_name, " silence left"}, '0, f.left);
            check_sample({test_name, " silence right"}, '0, f.right);
            quiet_frames++;
        end else if (f != '0) begin
            check_frame(test_name, exp_q.pop_front(), f);
        end
    endtask

    // I2S decoder, data is stable at the rising bit clock
    always @(posedge dac_bck_o) begin
        if (dac_lrck_o != prev_lrck) begin
            if (prev_lrck) begin
                if (synced && bck_count != FRAME_BCK) begin
                    $display("FAILED %s lrck period: expected %0d actual %0d",
                             test_name, FRAME_BCK, bck_count);
                    value_errs++;
                end
                if (synced) take_frame({left_acc, slot_acc});
                synced    = 1'b1;
                bck_count = 0;
            end else begin
                left_acc = slot_acc;
            end
            slot_pos = 0;
        end else begin
            slot_pos++;
        end
        prev_lrck = dac_lrck_o;
        bck_count++;
        if (slot_pos >= 1 && slot_pos <= SW) begin
            slot_acc = {slot_acc[SW-2:0], dac_data_o};
        end else if (synced && dac_data_o !== 1'b0) begin
            $display("FAILED %s pad bit %0d: expected 0 actual %b", test_name, slot_pos, dac_data_o);
            value_errs++;
        end
    end

    initial begin
        clk491520    = 1'b0;
        rst_ip       = 1'b1;
        in_word_i    = '0;
        in_valid_i   = 1'b0;
        lfsr_q       = 32'd52003;
        value_errs   = 0;
        other_errs   = 0;
        quiet_frames = 0;
        stalled      = 1'b0;
        slot_acc     = '0;
        left_acc     = '0;
        slot_pos     = 0;
        bck_count    = 0;
        prev_lrck    = 1'b1;
        synced       = 1'b0;
        test_name    = "reset";
        repeat (4) @(negedge clk491520);
        rst_ip = 1'b0;

        test_name = "ordered";
        repeat (20) push_pair();
        send_words(FRAME_CYC + 88);
        wait_drain();

        // Stray right first, then a doubled left
        test_name = "realign";
        push_word(1'b1);
        push_pair();
        push_word(1'b0);
        push_pair();
        push_pair();
        send_words(FRAME_CYC + 88);
        wait_drain();

        test_name = "burst";
        stalled = 1'b0;
        repeat (40) push_pair();
        send_words(0);
        if (!stalled) begin
            $display("burst: in_ready_o never went low");
            other_errs++;
        end
        wait_drain();

        test_name = "underrun";
        wait_quiet(4);
        repeat (5) push_pair();
        send_words(0);
        wait_drain();
        wait_quiet(1);

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dmix_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmix_cfg.svh"

module dmix_assertions import dmix_pkg::*; (
    input wire        clk491520,
    input wire        rst_ip,
    input chan_word_t in_word_i,
    input wire        in_valid_i,
    input wire        in_ready_i,
    input wire        pop_i,
    input wire        ack_i,
    input wire        frame_valid_i,
    input wire        rb_ready_i,
    input wire        bck_i,
    input wire        lrck_i
);

    rb_ptr_t occupancy_q;
    logic    push;
    logic    pull;

    // Frames held by the ring buffer, counted from its handshakes
    assign push = frame_valid_i && rb_ready_i;
    assign pull = pop_i && (occupancy_q != '0);

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            occupancy_q <= '0;
        end else begin
            occupancy_q <= occupancy_q + rb_ptr_t'(push) - rb_ptr_t'(pull);
        end
    end

    word_stable: assert property (@(posedge clk491520) disable iff (rst_ip)
        in_valid_i && !in_ready_i |=> $stable(in_word_i))
        else $error("input word changed while stalled");

    ack_after_pop: assert property (@(posedge clk491520) disable iff (rst_ip)
        pop_i |=> ack_i)
        else $error("pop not acknowledged in the next cycle");

    ack_needs_pop: assert property (@(posedge clk491520) disable iff (rst_ip)
        ack_i |-> $past(pop_i))
        else $error("ack without a pop one cycle before");

    // Word clock may only move with a falling bit clock
    lrck_on_bck_fall: assert property (@(posedge clk491520) disable iff (rst_ip)
        $changed(lrck_i) |-> $fell(bck_i))
        else $error("lrck changed away from a falling bit clock edge");

    ready_only_when_full: assert property (@(posedge clk491520) disable iff (rst_ip)
        !rb_ready_i |-> occupancy_q == rb_ptr_t'(`DMIX_RB_DEPTH))
        else $error("ring buffer refused a frame while not full");

endmodule

bind dmix_top dmix_assertions u_assertions (
    .clk491520     (clk491520),
    .rst_ip        (rst_ip),
    .in_word_i     (in_word_i),
    .in_valid_i    (in_valid_i),
    .in_ready_i    (in_ready_o),
    .pop_i         (dac_pop),
    .ack_i         (rb_ack),
    .frame_valid_i (pair_valid),
    .rb_ready_i    (rb_ready),
    .bck_i         (dac_bck_o),
    .lrck_i        (dac_lrck_o)
);

`default_nettype wire

//--- dmix_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmix_cfg.svh"

module dmix_top import dmix_pkg::*; (
    input  wire        clk491520,
    input  wire        rst_ip,
    input  chan_word_t in_word_i,
    input  wire        in_valid_i,
    output logic       in_ready_o,
    output logic       dac_bck_o,
    output logic       dac_lrck_o,
    output logic       dac_data_o
);

    frame_t pair_frame;
    logic   pair_valid;
    logic   rb_ready;
    logic   dac_pop;
    frame_t rb_frame;
    logic   rb_ack;

    sample_pairer u_pairer (
        .clk491520     (clk491520),
        .rst_ip        (rst_ip),
        .in_word_i     (in_word_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .frame_o       (pair_frame),
        .frame_valid_o (pair_valid),
        .frame_ready_i (rb_ready)
    );

    ringbuf u_rb (
        .clk491520     (clk491520),
        .rst_ip        (rst_ip),
        .frame_i       (pair_frame),
        .frame_valid_i (pair_valid),
        .frame_ready_o (rb_ready),
        .pop_i         (dac_pop),
        .frame_o       (rb_frame),
        .ack_o         (rb_ack)
    );

    dac_drv u_dac (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .frame_i    (rb_frame),
        .ack_i      (rb_ack),
        .pop_o      (dac_pop),
        .dac_bck_o  (dac_bck_o),
        .dac_lrck_o (dac_lrck_o),
        .dac_data_o (dac_data_o)
    );

endmodule

`default_nettype wire

//--- dac_drv.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmix_cfg.svh"

module dac_drv import dmix_pkg::*; (
    input  wire    clk491520,
    input  wire    rst_ip,
    input  frame_t frame_i,
    input  wire    ack_i,
    output logic   pop_o,
    output logic   dac_bck_o,
    output logic   dac_lrck_o,
    output logic   dac_data_o
);

    localparam int DIV   = `DMIX_BCK_DIV;
    localparam int HALF  = DIV / 2;
    localparam int CNT_W = $clog2(DIV);
    localparam int BIT_W = $clog2(2 * `DMIX_SLOT_BITS);
    localparam int SW    = `DMIX_SAMPLE_W;

    i2s_state_t             state_q;
    logic [CNT_W-1:0]       div_cnt_q;
    logic [BIT_W-1:0]       bit_idx_q;
    logic [2*SW-1:0]        sr_q;
    logic                   bck_q;
    logic                   lrck_q;
    logic                   data_q;
    logic                   pop_q;
    logic [BIT_W-2:0]       slot_pos;
    logic                   fall_evt;
    logic                   rise_evt;
    logic                   data_bit;

    assign slot_pos = bit_idx_q[BIT_W-2:0];
    assign fall_evt = (state_q == RUN) && (div_cnt_q == '0);
    assign rise_evt = (state_q == RUN) && (div_cnt_q == CNT_W'(HALF));

    // Sample bits occupy slot positions 1..SW, one period after the lrck edge
    assign data_bit = (slot_pos >= (BIT_W-1)'(1)) && (slot_pos <= (BIT_W-1)'(SW));

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            state_q   <= IDLE;
            div_cnt_q <= '0;
            bit_idx_q <= '0;
            bck_q     <= 1'b0;
            lrck_q    <= 1'b0;
            data_q    <= 1'b0;
            pop_q     <= 1'b0;
        end else begin
            pop_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    state_q <= RUN;
                end
                RUN: begin
                    if (div_cnt_q == CNT_W'(DIV - 1)) begin
                        div_cnt_q <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end else begin
                        div_cnt_q <= div_cnt_q + 1'b1;
                    end
                    if (fall_evt) begin
                        bck_q  <= 1'b0;
                        lrck_q <= bit_idx_q[BIT_W-1];
                        data_q <= data_bit ? sr_q[2*SW-1] : 1'b0;
                        // Fetch the next frame as its left slot begins
                        if (bit_idx_q == '0) begin
                            pop_q <= 1'b1;
                        end
                    end
                    if (rise_evt) begin
                        bck_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Left sample sits on top, right follows it out
    always_ff @(posedge clk491520) begin
        if (ack_i) begin
            sr_q <= {frame_i.left, frame_i.right};
        end else if (fall_evt && data_bit) begin
            sr_q <= {sr_q[2*SW-2:0], 1'b0};
        end
    end

    assign pop_o      = pop_q;
    assign dac_bck_o  = bck_q;
    assign dac_lrck_o = lrck_q;
    assign dac_data_o = data_q;

endmodule

`default_nettype wire

//--- ringbuf.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmix_cfg.svh"

module ringbuf import dmix_pkg::*; (
    input  wire    clk491520,
    input  wire    rst_ip,
    input  frame_t frame_i,
    input  wire    frame_valid_i,
    output logic   frame_ready_o,
    input  wire    pop_i,
    output frame_t frame_o,
    output logic   ack_o
);

    localparam int AW = `DMIX_RB_AW;

    frame_t  mem [`DMIX_RB_DEPTH];
    rb_ptr_t wr_ptr_q;
    rb_ptr_t rd_ptr_q;
    frame_t  rd_frame_q;
    logic    ack_q;
    logic    full;
    logic    empty;
    logic    wr_en;
    logic    rd_en;

    // Same index with differing wrap bits means full
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign frame_ready_o = !full;
    assign wr_en         = frame_valid_i && !full;
    assign rd_en         = pop_i && !empty;

    always_ff @(posedge clk491520) begin
        if (wr_en) begin
            mem[wr_ptr_q[AW-1:0]] <= frame_i;
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            ack_q    <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + rb_ptr_t'(1);
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + rb_ptr_t'(1);
            end
            ack_q <= pop_i;
        end
    end

    // Oldest frame on pop, silence on underrun
    always_ff @(posedge clk491520) begin
        if (pop_i) begin
            rd_frame_q <= rd_en ? mem[rd_ptr_q[AW-1:0]] : '0;
        end
    end

    assign frame_o = rd_frame_q;
    assign ack_o   = ack_q;

endmodule

`default_nettype wire

//--- sample_pairer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmix_cfg.svh"

module sample_pairer import dmix_pkg::*; (
    input  wire        clk491520,
    input  wire        rst_ip,
    input  chan_word_t in_word_i,
    input  wire        in_valid_i,
    output logic       in_ready_o,
    output frame_t     frame_o,
    output logic       frame_valid_o,
    input  wire        frame_ready_i
);

    sample_t left_q;
    logic    left_vld_q;
    frame_t  frame_q;
    logic    frame_vld_q;
    logic    run_q;
    logic    accept;

    // Stall input while the output register cannot take a new frame
    assign in_ready_o = run_q && (!frame_vld_q || frame_ready_i);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            run_q       <= 1'b0;
            left_vld_q  <= 1'b0;
            frame_vld_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (frame_vld_q && frame_ready_i) begin
                frame_vld_q <= 1'b0;
            end
            if (accept) begin
                if (!in_word_i.is_right) begin
                    // A newer left word simply replaces the held one
                    left_vld_q <= 1'b1;
                end else if (left_vld_q) begin
                    left_vld_q  <= 1'b0;
                    frame_vld_q <= 1'b1;
                end
                // Orphan right word falls through here, realigning the pair
            end
        end
    end

    always_ff @(posedge clk491520) begin
        if (accept && !in_word_i.is_right) begin
            left_q <= in_word_i.data;
        end
        if (accept && in_word_i.is_right && left_vld_q) begin
            frame_q.left  <= left_q;
            frame_q.right <= in_word_i.data;
        end
    end

    assign frame_o       = frame_q;
    assign frame_valid_o = frame_vld_q;

endmodule

`default_nettype wire

//--- dmix_pkg.sv
`default_nettype none

`include "dmix_cfg.svh"

package dmix_pkg;

    // One signed PCM sample
    typedef logic signed [`DMIX_SAMPLE_W-1:0] sample_t;

    // Channel word as delivered by the receiver
    typedef struct packed {
        sample_t data;
        logic    is_right;
    } chan_word_t;

    // Stereo frame
    typedef struct packed {
        sample_t left;
        sample_t right;
    } frame_t;

    // Ring pointer, top bit is the wrap flag
    typedef logic [`DMIX_RB_AW:0] rb_ptr_t;

    typedef enum logic {
        IDLE,
        RUN
    } i2s_state_t;

endpackage

`default_nettype wire

//--- dmix_cfg.svh
`ifndef DMIX_CFG_SVH
`define DMIX_CFG_SVH

// Audio sample width in bits
`define DMIX_SAMPLE_W 24

// Frame ring buffer geometry, depth must be a power of two
`define DMIX_RB_DEPTH 16
`define DMIX_RB_AW 4

// clk491520 cycles per bit clock period, even
`define DMIX_BCK_DIV 8

// Bit clock periods per channel slot
`define DMIX_SLOT_BITS 32

`endif
